//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_core_tb
RTL_TOP   ?= cpu_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/hazard_unit.sv
logic/cpu_core.sv
tests/tb_clock_gen.sv
tests/cpu_core_tb.sv

//--- logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] im_addr,
    input  logic [xlen-1:0] im_dout,
    output logic [xlen-1:0] mem_addr,
    output logic            mem_we,
    output logic [xlen-1:0] mem_din,
    input  logic [xlen-1:0] mem_dout
);

    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    mem_wb_t         mem_wb;
    ctrl_t           ctrl_id;
    logic [xlen-1:0] imm_id;
    logic [xlen-1:0] rd0_id;
    logic [xlen-1:0] rd1_id;
    logic [xlen-1:0] alu_ans_ex;
    logic [xlen-1:0] store_data_ex;
    logic [xlen-1:0] target;
    logic            redirect;
    logic [1:0]      fwd0_sel;
    logic [1:0]      fwd1_sel;
    logic            stall;
    logic            flush_if_id;
    logic            flush_id_ex;
    logic [xlen-1:0] mem_fwd;
    logic [xlen-1:0] wb_data;

    function automatic logic [xlen-1:0] wd_mux(
        input logic [1:0]      sel,
        input logic [xlen-1:0] alu_val,
        input logic [xlen-1:0] pc4_val,
        input logic [xlen-1:0] mem_val,
        input logic [xlen-1:0] imm_val
    );
        case (sel)
            wd_pc4:  return pc4_val;
            wd_mem:  return mem_val;
            wd_imm:  return imm_val;
            default: return alu_val;
        endcase
    endfunction

    fetch_stage u_fetch (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush_if_id),
        .redirect (redirect),
        .target   (target),
        .im_dout  (im_dout),
        .im_addr  (im_addr),
        .if_id    (if_id)
    );

    decode_unit u_decode (
        .inst (if_id.inst),
        .ctrl (ctrl_id),
        .imm  (imm_id)
    );

    reg_file u_rf (
        .clk (clk),
        .ra0 (if_id.inst.r.rs1),
        .ra1 (if_id.inst.r.rs2),
        .wa  (mem_wb.wa),
        .we  (mem_wb.ctrl.rf_we),
        .wd  (wb_data),
        .rd0 (rd0_id),
        .rd1 (rd1_id)
    );

    always_ff @(posedge clk) begin
        id_ex <= '{pc: if_id.pc, pc4: if_id.pc4, rd0: rd0_id, rd1: rd1_id, imm: imm_id,
                   ra0: if_id.inst.r.rs1, ra1: if_id.inst.r.rs2, wa: if_id.inst.r.rd,
                   ctrl: ctrl_id};
        if (reset || flush_id_ex)
            id_ex.ctrl <= '0;  // Bubble
    end

    execute_stage u_execute (
        .id_ex      (id_ex),
        .fwd0_sel   (fwd0_sel),
        .fwd1_sel   (fwd1_sel),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_data),
        .alu_ans    (alu_ans_ex),
        .store_data (store_data_ex),
        .target     (target),
        .redirect   (redirect)
    );

    always_ff @(posedge clk) begin
        ex_mem <= '{alu_ans: alu_ans_ex, pc4: id_ex.pc4, imm: id_ex.imm,
                    store_data: store_data_ex, wa: id_ex.wa, ctrl: id_ex.ctrl};
        if (reset)
            ex_mem.ctrl <= '0;
    end

    assign mem_addr = ex_mem.alu_ans;
    assign mem_din  = ex_mem.store_data;
    assign mem_we   = ex_mem.ctrl.mem_we;

    // A load never forwards from here since the stall has already split it off
    assign mem_fwd = wd_mux(ex_mem.ctrl.wd_sel, ex_mem.alu_ans, ex_mem.pc4, mem_dout,
                            ex_mem.imm);

    always_ff @(posedge clk) begin
        mem_wb <= '{alu_ans: ex_mem.alu_ans, pc4: ex_mem.pc4, imm: ex_mem.imm,
                    load_data: mem_dout, wa: ex_mem.wa, ctrl: ex_mem.ctrl};
        if (reset)
            mem_wb.ctrl <= '0;
    end

    assign wb_data = wd_mux(mem_wb.ctrl.wd_sel, mem_wb.alu_ans, mem_wb.pc4, mem_wb.load_data,
                            mem_wb.imm);

    hazard_unit u_hazard (
        .ra0_id      (if_id.inst.r.rs1),
        .ra1_id      (if_id.inst.r.rs2),
        .ra0_ex      (id_ex.ra0),
        .ra1_ex      (id_ex.ra1),
        .wa_ex       (id_ex.wa),
        .wa_mem      (ex_mem.wa),
        .wa_wb       (mem_wb.wa),
        .ctrl_id     (ctrl_id),
        .ctrl_ex     (id_ex.ctrl),
        .ctrl_mem    (ex_mem.ctrl),
        .ctrl_wb     (mem_wb.ctrl),
        .redirect    (redirect),
        .fwd0_sel    (fwd0_sel),
        .fwd1_sel    (fwd1_sel),
        .stall       (stall),
        .flush_if_id (flush_if_id),
        .flush_id_ex (flush_id_ex)
    );

    assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.ctrl.mem_we && ex_mem.ctrl.mem_re))
        else $error("load and store both active in memory stage");

    assert property (@(posedge clk) disable iff (reset)
        ex_mem.ctrl.mem_re |-> fwd0_sel != fwd_mem && fwd1_sel != fwd_mem)
        else $error("load in memory stage selected as forward source");

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import rv_pkg::*; (
    input  inst_u           inst,
    output ctrl_t           ctrl,
    output logic [xlen-1:0] imm
);

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic            alt;
    logic            f7_ok;

    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm, 12'b0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    // sub and sra
    assign alt   = inst.r.funct7 == 7'b0100000;
    assign f7_ok = inst.r.funct7 == 7'b0000000
                || (alt && (inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101));

    function automatic logic [3:0] alu_of(input logic [2:0] funct3, input logic sel_alt);
        case (funct3)
            3'b000:  return sel_alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return sel_alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        ctrl         = '0;
        ctrl.br_type = br_none;
        imm          = '0;
        case (inst.r.opcode)
            op_reg: if (f7_ok) begin
                ctrl.rf_we    = 1'b1;
                ctrl.wd_sel   = wd_alu;
                ctrl.re0      = 1'b1;
                ctrl.re1      = 1'b1;
                ctrl.alu_func = alu_of(inst.r.funct3, alt);
            end
            // addi, slti, xori, ori, andi only
            op_imm: if (inst.i.funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) begin
                ctrl.rf_we    = 1'b1;
                ctrl.re0      = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.alu_func = alu_of(inst.i.funct3, 1'b0);
                imm           = imm_i;
            end
            op_load: if (inst.i.funct3 == 3'b010) begin
                ctrl.rf_we    = 1'b1;
                ctrl.wd_sel   = wd_mem;
                ctrl.re0      = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.mem_re   = 1'b1;
                imm           = imm_i;
            end
            op_store: if (inst.s.funct3 == 3'b010) begin
                ctrl.re0      = 1'b1;
                ctrl.re1      = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.mem_we   = 1'b1;
                imm           = imm_s;
            end
            op_branch: if (inst.b.funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) begin
                ctrl.re0      = 1'b1;
                ctrl.re1      = 1'b1;
                ctrl.src1_pc  = 1'b1;  // ALU forms pc + imm as the target
                ctrl.src2_imm = 1'b1;
                case (inst.b.funct3)
                    3'b000:  ctrl.br_type = br_eq;
                    3'b001:  ctrl.br_type = br_ne;
                    3'b100:  ctrl.br_type = br_lt;
                    default: ctrl.br_type = br_ge;
                endcase
                imm = imm_b;
            end
            op_jal: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wd_sel   = wd_pc4;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.jal      = 1'b1;
                imm           = imm_j;
            end
            op_jalr: if (inst.i.funct3 == 3'b000) begin
                ctrl.rf_we    = 1'b1;
                ctrl.wd_sel   = wd_pc4;
                ctrl.re0      = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.jalr     = 1'b1;
                imm           = imm_i;
            end
            op_lui: begin
                ctrl.rf_we  = 1'b1;
                ctrl.wd_sel = wd_imm;
                imm         = imm_u;
            end
            op_auipc: begin
                ctrl.rf_we    = 1'b1;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
                imm           = imm_u;
            end
            default: ;  // Anything else runs as a nop
        endcase
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  id_ex_t          id_ex,
    input  logic [1:0]      fwd0_sel,
    input  logic [1:0]      fwd1_sel,
    input  logic [xlen-1:0] mem_fwd,
    input  logic [xlen-1:0] wb_fwd,
    output logic [xlen-1:0] alu_ans,
    output logic [xlen-1:0] store_data,
    output logic [xlen-1:0] target,
    output logic            redirect
);

    logic [xlen-1:0] op0;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic            taken;

    function automatic logic [xlen-1:0] fwd_mux(
        input logic [1:0]      sel,
        input logic [xlen-1:0] reg_val,
        input logic [xlen-1:0] mem_val,
        input logic [xlen-1:0] wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op0        = fwd_mux(fwd0_sel, id_ex.rd0, mem_fwd, wb_fwd);
    assign op1        = fwd_mux(fwd1_sel, id_ex.rd1, mem_fwd, wb_fwd);
    assign src1       = id_ex.ctrl.src1_pc ? id_ex.pc : op0;
    assign src2       = id_ex.ctrl.src2_imm ? id_ex.imm : op1;
    assign store_data = op1;

    always_comb begin
        case (id_ex.ctrl.alu_func)
            alu_sub:  alu_ans = src1 - src2;
            alu_and:  alu_ans = src1 & src2;
            alu_or:   alu_ans = src1 | src2;
            alu_xor:  alu_ans = src1 ^ src2;
            alu_slt:  alu_ans = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            alu_sltu: alu_ans = {{(xlen-1){1'b0}}, src1 < src2};
            alu_sll:  alu_ans = src1 << src2[4:0];
            alu_srl:  alu_ans = src1 >> src2[4:0];
            alu_sra:  alu_ans = $unsigned($signed(src1) >>> src2[4:0]);
            default:  alu_ans = src1 + src2;  // alu_add
        endcase
    end

    // Compare on the forwarded register values, not on the ALU inputs
    always_comb begin
        case (id_ex.ctrl.br_type)
            br_eq:   taken = op0 == op1;
            br_ne:   taken = op0 != op1;
            br_lt:   taken = $signed(op0) < $signed(op1);
            br_ge:   taken = $signed(op0) >= $signed(op1);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = taken || id_ex.ctrl.jal || id_ex.ctrl.jalr;
    assign target   = id_ex.ctrl.jalr ? {alu_ans[xlen-1:1], 1'b0} : alu_ans;

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  logic            redirect,
    input  logic [xlen-1:0] target,
    input  logic [xlen-1:0] im_dout,
    output logic [xlen-1:0] im_addr,
    output if_id_t          if_id
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc4;

    assign pc4     = pc + 32'd4;
    assign im_addr = pc;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= '0;
        else if (redirect)  // Redirect wins over a load-use hold
            pc <= target;
        else if (!stall)
            pc <= pc4;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            if_id.pc   <= '0;
            if_id.pc4  <= '0;
            if_id.inst <= inst_u'(nop_inst);  // Squashed slot
        end else if (!stall) begin
            if_id.pc   <= pc;
            if_id.pc4  <= pc4;
            if_id.inst <= inst_u'(im_dout);
        end
    end

    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("fetch pc %h not word aligned", pc);

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    input  logic [reg_addr_w-1:0] ra0_id,
    input  logic [reg_addr_w-1:0] ra1_id,
    input  logic [reg_addr_w-1:0] ra0_ex,
    input  logic [reg_addr_w-1:0] ra1_ex,
    input  logic [reg_addr_w-1:0] wa_ex,
    input  logic [reg_addr_w-1:0] wa_mem,
    input  logic [reg_addr_w-1:0] wa_wb,
    input  ctrl_t                 ctrl_id,
    input  ctrl_t                 ctrl_ex,
    input  ctrl_t                 ctrl_mem,
    input  ctrl_t                 ctrl_wb,
    input  logic                  redirect,
    output logic [1:0]            fwd0_sel,
    output logic [1:0]            fwd1_sel,
    output logic                  stall,
    output logic                  flush_if_id,
    output logic                  flush_id_ex
);

    function automatic logic [1:0] fwd_pick(input logic [reg_addr_w-1:0] ra, input logic re);
        logic live;
        live = re && ra != '0;
        if (live && ctrl_mem.rf_we && wa_mem == ra)
            return fwd_mem;  // Younger result first
        else if (live && ctrl_wb.rf_we && wa_wb == ra)
            return fwd_wb;
        else
            return fwd_none;
    endfunction

    always_comb begin
        fwd0_sel = fwd_pick(ra0_ex, ctrl_ex.re0);
        fwd1_sel = fwd_pick(ra1_ex, ctrl_ex.re1);
    end

    // Load in EX feeding the instruction in ID
    assign stall = ctrl_ex.mem_re && wa_ex != '0
                && ((ctrl_id.re0 && ra0_id == wa_ex) || (ctrl_id.re1 && ra1_id == wa_ex));

    assign flush_if_id = redirect;
    assign flush_id_ex = redirect || stall;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] ra0,
    input  logic [reg_addr_w-1:0] ra1,
    input  logic [reg_addr_w-1:0] wa,
    input  logic                  we,
    input  logic [xlen-1:0]       wd,
    output logic [xlen-1:0]       rd0,
    output logic [xlen-1:0]       rd1
);

    logic [xlen-1:0] regs [1:31];  // x0 has no storage

    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] ra);
        if (ra == '0)
            return '0;
        else if (we && wa == ra)
            return wd;  // Writeback lands in the same cycle
        else
            return regs[ra];
    endfunction

    always_comb begin
        rd0 = read_port(ra0);
        rd1 = read_port(ra1);
    end

    always_ff @(posedge clk) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    assert property (@(posedge clk) ra0 == '0 |-> rd0 == '0);
    assert property (@(posedge clk) ra1 == '0 |-> rd1 == '0);

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    localparam logic [3:0] alu_add  = 4'd0;  // Zero control means add
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_and  = 4'd2;
    localparam logic [3:0] alu_or   = 4'd3;
    localparam logic [3:0] alu_xor  = 4'd4;
    localparam logic [3:0] alu_slt  = 4'd5;
    localparam logic [3:0] alu_sltu = 4'd6;
    localparam logic [3:0] alu_sll  = 4'd7;
    localparam logic [3:0] alu_srl  = 4'd8;
    localparam logic [3:0] alu_sra  = 4'd9;

    localparam logic [2:0] br_none = 3'd0;
    localparam logic [2:0] br_eq   = 3'd1;
    localparam logic [2:0] br_ne   = 3'd2;
    localparam logic [2:0] br_lt   = 3'd3;
    localparam logic [2:0] br_ge   = 3'd4;

    localparam logic [1:0] wd_alu = 2'd0;
    localparam logic [1:0] wd_pc4 = 2'd1;
    localparam logic [1:0] wd_mem = 2'd2;
    localparam logic [1:0] wd_imm = 2'd3;

    // Operand source in execute
    localparam logic [1:0] fwd_none = 2'd0;
    localparam logic [1:0] fwd_mem  = 2'd1;
    localparam logic [1:0] fwd_wb   = 2'd2;

    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;  // addi x0, x0, 0

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        logic       rf_we;
        logic [1:0] wd_sel;
        logic       src1_pc;
        logic       src2_imm;
        logic [3:0] alu_func;
        logic [2:0] br_type;
        logic       jal, jalr;
        logic       mem_we, mem_re;
        logic       re0, re1;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc, pc4;
        inst_u           inst;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc, pc4;
        logic [xlen-1:0]       rd0, rd1;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] ra0, ra1, wa;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_ans, pc4, imm;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] wa;
        ctrl_t                 ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_ans, pc4, imm;
        logic [xlen-1:0]       load_data;
        logic [reg_addr_w-1:0] wa;
        ctrl_t                 ctrl;
    } mem_wb_t;

endpackage

//--- tests/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

    localparam int num_entries = 8;
    localparam int max_words   = 16;
    localparam int max_stores  = 4;
    localparam int run_cycles  = 48;

    logic        clk;
    logic        por;
    logic        tb_rst;
    logic [31:0] im_addr;
    logic [31:0] im_dout;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [31:0] mem_din;
    logic [31:0] mem_dout;

    logic [31:0] imem [0:max_words-1];
    logic [31:0] dmem [0:63];
    logic [31:0] prog [num_entries][max_words];
    int          prog_n [num_entries];
    logic [31:0] exp_addr [num_entries][max_stores];
    logic [31:0] exp_data [num_entries][max_stores];
    int          exp_n [num_entries];
    int          cur;
    integer      seed;

    tb_clock_gen clock_gen (.clk(clk), .reset(por));

    cpu_core dut (
        .clk      (clk),
        .reset    (por || tb_rst),
        .im_addr  (im_addr),
        .im_dout  (im_dout),
        .mem_addr (mem_addr),
        .mem_we   (mem_we),
        .mem_din  (mem_din),
        .mem_dout (mem_dout)
    );

    // Past the program the core only sees nops
    assign im_dout  = (im_addr[31:6] == '0) ? imem[im_addr[5:2]] : 32'h0000_0013;
    assign mem_dout = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (mem_we)
            dmem[mem_addr[7:2]] <= mem_din;
    end

    function automatic logic [31:0] mem_fill(input logic [31:0] addr);
        return 32'h5a5a_0000 ^ (addr << 20) ^ (addr * 32'h0001_0103);
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input int rd, input int rs1,
                                           input int rs2, input logic [2:0] f3);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input int rd, input int rs1, input logic [11:0] imm,
                                           input logic [2:0] f3, input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] sw_word(input int rs2, input logic [11:0] off, input int rs1);
        return {off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input int rs1, input int rs2,
                                           input logic [12:0] off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(input int rd, input logic [19:0] imm,
                                           input logic [6:0] op);
        return {imm, 5'(rd), op};
    endfunction

    function automatic logic [31:0] jal_word(input int rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] lui_addi_value(input logic [19:0] hi, input logic [11:0] lo);
        return {hi, 12'b0} + {{20{lo[11]}}, lo};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[cur][prog_n[cur]] = word;
        prog_n[cur]++;
    endtask

    task automatic want_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr[cur][exp_n[cur]] = addr;
        exp_data[cur][exp_n[cur]] = data;
        exp_n[cur]++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic random_entry();
        logic [19:0] hi_a;
        logic [19:0] hi_b;
        logic [11:0] lo_a;
        logic [11:0] lo_b;
        logic [31:0] a;
        logic [31:0] b;
        hi_a = $random(seed);
        lo_a = $random(seed);
        hi_b = $random(seed);
        lo_b = $random(seed);
        a = lui_addi_value(hi_a, lo_a);
        b = lui_addi_value(hi_b, lo_b);
        emit(u_word(3, hi_a, 7'b0110111));
        emit(i_word(3, 3, lo_a, 3'b000, 7'b0010011));
        emit(u_word(4, hi_b, 7'b0110111));
        emit(i_word(4, 4, lo_b, 3'b000, 7'b0010011));
        emit(r_word(7'h00, 5, 3, 4, 3'b000));
        emit(sw_word(3, 12'h70, 0));
        emit(sw_word(4, 12'h74, 0));
        emit(sw_word(5, 12'h78, 0));
        want_store(32'h70, a);
        want_store(32'h74, b);
        want_store(32'h78, a + b);
    endtask

    task automatic build_table();
        for (int e = 0; e < num_entries; e++) begin
            prog_n[e] = 0;
            exp_n[e]  = 0;
        end
        cur = 0;  // Register ALU ops forwarded back to back
        emit(i_word(1, 0, 12'd100, 3'b000, 7'b0010011));
        emit(i_word(2, 0, -12'sd7, 3'b000, 7'b0010011));
        emit(r_word(7'h00, 3, 1, 2, 3'b000));
        emit(r_word(7'h20, 4, 3, 1, 3'b000));
        emit(sw_word(3, 12'd0, 0));
        emit(r_word(7'h00, 5, 4, 1, 3'b111));
        emit(r_word(7'h00, 6, 5, 2, 3'b110));
        emit(r_word(7'h00, 7, 6, 1, 3'b100));
        emit(sw_word(7, 12'd4, 0));
        emit(r_word(7'h00, 8, 2, 1, 3'b010));
        emit(r_word(7'h00, 9, 1, 8, 3'b001));
        emit(sw_word(9, 12'd8, 0));
        emit(r_word(7'h20, 10, 2, 8, 3'b101));
        emit(r_word(7'h00, 11, 10, 8, 3'b101));
        emit(sw_word(11, 12'd12, 0));
        want_store(32'd0, 32'd93);
        want_store(32'd4, 32'hffff_ff9d);
        want_store(32'd8, 32'd200);
        want_store(32'd12, 32'h7fff_fffe);

        cur = 1;  // Immediate forms and sltu
        emit(i_word(1, 0, -12'sd20, 3'b000, 7'b0010011));
        emit(i_word(2, 1, 12'h0f0, 3'b111, 7'b0010011));
        emit(i_word(3, 2, 12'h005, 3'b110, 7'b0010011));
        emit(i_word(4, 3, 12'hfff, 3'b100, 7'b0010011));
        emit(sw_word(4, 12'd16, 0));
        emit(i_word(5, 1, -12'sd19, 3'b010, 7'b0010011));
        emit(r_word(7'h00, 6, 5, 1, 3'b011));
        emit(r_word(7'h00, 7, 5, 6, 3'b000));
        emit(sw_word(7, 12'd20, 0));
        emit(sw_word(3, 12'd24, 0));
        emit(i_word(8, 4, 12'd0, 3'b010, 7'b0010011));
        emit(sw_word(8, 12'd28, 0));
        want_store(32'd16, 32'hffff_ff1a);
        want_store(32'd20, 32'd2);
        want_store(32'd24, 32'h0000_00e5);
        want_store(32'd28, 32'd1);

        cur = 2;  // Load-use on both ALU operand and store data
        emit(i_word(1, 0, 12'd40, 3'b010, 7'b0000011));
        emit(i_word(2, 1, 12'd13, 3'b000, 7'b0010011));
        emit(sw_word(2, 12'd44, 0));
        emit(i_word(3, 0, 12'd44, 3'b010, 7'b0000011));
        emit(sw_word(3, 12'd48, 0));
        emit(i_word(4, 0, 12'd52, 3'b010, 7'b0000011));
        emit(r_word(7'h00, 5, 4, 4, 3'b000));
        emit(sw_word(5, 12'd56, 0));
        want_store(32'd44, mem_fill(32'd40) + 32'd13);
        want_store(32'd48, mem_fill(32'd40) + 32'd13);
        want_store(32'd56, mem_fill(32'd52) * 2);

        cur = 3;  // Taken branches squash two slots each
        emit(i_word(1, 0, 12'd5, 3'b000, 7'b0010011));
        emit(i_word(2, 0, -12'sd3, 3'b000, 7'b0010011));
        emit(b_word(3'b000, 1, 1, 13'd12));
        emit(sw_word(1, 12'd60, 0));
        emit(sw_word(2, 12'd60, 0));
        emit(b_word(3'b001, 1, 1, 13'd8));
        emit(sw_word(1, 12'd64, 0));
        emit(b_word(3'b100, 2, 1, 13'd12));
        emit(sw_word(1, 12'd68, 0));
        emit(sw_word(1, 12'd68, 0));
        emit(b_word(3'b101, 2, 1, 13'd8));
        emit(sw_word(2, 12'd72, 0));
        emit(b_word(3'b101, 1, 2, 13'd12));
        emit(sw_word(1, 12'd76, 0));
        emit(sw_word(1, 12'd76, 0));
        emit(sw_word(2, 12'd80, 0));
        want_store(32'd64, 32'd5);
        want_store(32'd72, 32'hffff_fffd);
        want_store(32'd80, 32'hffff_fffd);

        cur = 4;  // jal, jalr with odd target, jal to x0
        emit(i_word(1, 0, 12'd5, 3'b000, 7'b0010011));
        emit(jal_word(2, 21'd12));
        emit(sw_word(1, 12'd84, 0));
        emit(sw_word(1, 12'd84, 0));
        emit(sw_word(2, 12'd84, 0));
        emit(i_word(3, 0, 12'd37, 3'b000, 7'b0010011));
        emit(i_word(4, 3, 12'd0, 3'b000, 7'b1100111));
        emit(sw_word(1, 12'd88, 0));
        emit(sw_word(1, 12'd88, 0));
        emit(sw_word(4, 12'd88, 0));
        emit(jal_word(0, 21'd8));
        emit(sw_word(1, 12'd92, 0));
        emit(sw_word(0, 12'd92, 0));
        want_store(32'd84, 32'd8);
        want_store(32'd88, 32'd28);
        want_store(32'd92, 32'd0);

        cur = 5;  // Writes to x0, lui and auipc
        emit(i_word(0, 0, 12'd55, 3'b000, 7'b0010011));
        emit(sw_word(0, 12'd96, 0));
        emit(u_word(1, 20'h12345, 7'b0110111));
        emit(sw_word(1, 12'd100, 0));
        emit(u_word(2, 20'h00010, 7'b0010111));
        emit(sw_word(2, 12'd104, 0));
        want_store(32'd96, 32'd0);
        want_store(32'd100, 32'h1234_5000);
        want_store(32'd104, 32'h0001_0010);

        cur = 6;
        random_entry();
        cur = 7;
        random_entry();
    endtask

    task automatic load_entry(input int e);
        for (int k = 0; k < max_words; k++)
            imem[k] = (k < prog_n[e]) ? prog[e][k] : 32'h0000_0013;
        for (int k = 0; k < 64; k++)
            dmem[k] = mem_fill(32'(k * 4));
    endtask

    task automatic run_entry(input int e);
        int got;
        int extra;
        int cycles;
        got    = 0;
        extra  = 0;
        cycles = 0;
        @(negedge clk) tb_rst = 1'b1;
        load_entry(e);
        repeat (4) begin
            @(negedge clk);
            check_value("im_addr in reset", im_addr, 32'd0);
            check_value("mem_we in reset", 32'(mem_we), 32'd0);
        end
        tb_rst = 1'b0;
        check_value("im_addr after reset", im_addr, 32'd0);
        @(negedge clk);
        while (cycles < run_cycles && (got < exp_n[e] || extra < 8)) begin
            if (mem_we) begin
                if (got >= exp_n[e]) begin
                    $display("Entry %0d wrote an unexpected store to %h at %0t",
                             e, mem_addr, $time);
                    $display("Verification failed");
                    $fatal(1);
                end
                check_value("mem_addr", mem_addr, exp_addr[e][got]);
                check_value("mem_din", mem_din, exp_data[e][got]);
                got++;
            end else if (got == exp_n[e]) begin
                extra++;  // Quiet tail catches late stray stores
            end
            cycles++;
            @(negedge clk);
        end
        if (got < exp_n[e]) begin
            $display("Entry %0d saw only %0d of %0d stores", e, got, exp_n[e]);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    initial begin
        #((num_entries * 64 + 16) * 8);
        $display("Watchdog expired before all programs finished");
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        seed   = 32'h1267_d8f7;
        tb_rst = 1'b0;
        build_table();
        load_entry(0);
        wait (por == 1'b0);
        for (int e = 0; e < num_entries; e++)
            run_entry(e);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        repeat (4) @(posedge clk);
        @(negedge clk) reset = 1'b0;
    end

endmodule
